//--- logic/vec_pkg.sv
package vec_pkg;

  ////////////////////
  // Element types
  ////////////////////

  // One vector element is one 16-bit word
  localparam int unsigned ElemWidth = 16;

  typedef logic [ElemWidth-1:0] elem_t;

  // Lane count used when the top level is not overridden
  localparam int unsigned DefNrLanes = 4;

  ////////////////////
  // Lane opcodes
  ////////////////////

  // Lanes pass vs2 for the reserved codes 6 and 7
  typedef enum logic [2:0] {
    VADD  = 3'd0,
    VSUB  = 3'd1,
    VAND  = 3'd2,
    VOR   = 3'd3,
    VXOR  = 3'd4,
    VMINU = 3'd5
  } vec_op_e;

endpackage : vec_pkg

//--- logic/vec_lane.sv
`timescale 1ns/1ns

module vec_lane (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              valid_i,
  input  vec_pkg::vec_op_e  op_i,
  input  vec_pkg::elem_t    vs1_i,
  input  vec_pkg::elem_t    vs2_i,
  output logic              valid_o,
  output vec_pkg::elem_t    res_o
);

  import vec_pkg::*;

  elem_t alu_res;

  ////////////////////
  // Element ALU
  ////////////////////

  // Operand order is vs2 op vs1
  always_comb begin
    case (op_i)
      VADD:    alu_res = vs2_i + vs1_i;
      VSUB:    alu_res = vs2_i - vs1_i;
      VAND:    alu_res = vs2_i & vs1_i;
      VOR:     alu_res = vs2_i | vs1_i;
      VXOR:    alu_res = vs2_i ^ vs1_i;
      VMINU:   alu_res = (vs2_i < vs1_i) ? vs2_i : vs1_i;
      // Reserved codes
      default: alu_res = vs2_i;
    endcase
  end

  ////////////////////
  // Output stage
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // Result only loads on an accepted instruction
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      res_o <= alu_res;
    end
  end

endmodule : vec_lane

//--- logic/vec_mask_unit.sv
`timescale 1ns/1ns

module vec_mask_unit #(
  parameter  int unsigned NrLanes  = vec_pkg::DefNrLanes,
  localparam int unsigned CntWidth = $clog2(NrLanes + 1)
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              valid_i,
  input  vec_pkg::elem_t [NrLanes-1:0]      vs1_i,
  input  vec_pkg::elem_t [NrLanes-1:0]      vs2_i,
  input  vec_pkg::elem_t [NrLanes-1:0]      vd_i,
  input  logic           [NrLanes-1:0]      vm_i,
  input  logic                              masked_i,
  output logic           [NrLanes-1:0]      active_o,
  output logic           [NrLanes-1:0]      cmp_o,
  output vec_pkg::elem_t [NrLanes-1:0]      vd_o,
  output logic           [CntWidth-1:0]     count_o
);

  logic [NrLanes-1:0]  active_d;
  logic [NrLanes-1:0]  cmp_d;
  logic [CntWidth-1:0] count_d;

  ////////////////////
  // Active elements
  ////////////////////

  // Unmasked instructions touch every element
  assign active_d = masked_i ? vm_i : '1;

  ////////////////////
  // Compare and count
  ////////////////////

  // Unsigned vs2 < vs1 per element and a count of the active hits
  always_comb begin
    count_d = '0;
    for (int unsigned l = 0; l < NrLanes; l++) begin
      cmp_d[l] = vs2_i[l] < vs1_i[l];
      if (cmp_d[l] && active_d[l]) begin
        count_d = count_d + CntWidth'(1);
      end
    end
  end

  ////////////////////
  // Output stage
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      active_o <= '0;
      cmp_o    <= '0;
    end else if (valid_i) begin
      active_o <= active_d;
      cmp_o    <= cmp_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      vd_o    <= vd_i;
      count_o <= count_d;
    end
  end

endmodule : vec_mask_unit

//--- logic/vec_merge.sv
`timescale 1ns/1ns

module vec_merge #(
  parameter  int unsigned NrLanes  = vec_pkg::DefNrLanes,
  localparam int unsigned CntWidth = $clog2(NrLanes + 1)
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              valid_i,
  input  vec_pkg::elem_t [NrLanes-1:0]      lane_res_i,
  input  logic           [NrLanes-1:0]      active_i,
  input  logic           [NrLanes-1:0]      cmp_i,
  input  vec_pkg::elem_t [NrLanes-1:0]      vd_i,
  input  logic           [CntWidth-1:0]     count_i,
  output logic                              out_valid_o,
  output vec_pkg::elem_t [NrLanes-1:0]      res_data_o,
  output logic           [NrLanes-1:0]      res_mask_o,
  output logic           [CntWidth-1:0]     res_count_o
);

  import vec_pkg::*;

  elem_t [NrLanes-1:0] merged;

  ////////////////////
  // Element select
  ////////////////////

  // Inactive elements keep the old destination value
  always_comb begin
    for (int unsigned l = 0; l < NrLanes; l++) begin
      merged[l] = active_i[l] ? lane_res_i[l] : vd_i[l];
    end
  end

  ////////////////////
  // Output stage
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_valid_o <= 1'b0;
    end else begin
      out_valid_o <= valid_i;
    end
  end

  // Count arrives finished from the mask unit
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      res_data_o  <= merged;
      res_mask_o  <= cmp_i & active_i;
      res_count_o <= count_i;
    end
  end

endmodule : vec_merge

//--- logic/vec_top.sv
`timescale 1ns/1ns

module vec_top #(
  parameter  int unsigned NrLanes  = vec_pkg::DefNrLanes,
  localparam int unsigned CntWidth = $clog2(NrLanes + 1)
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  // Instruction strobe without back-pressure
  input  logic                              in_valid_i,
  input  vec_pkg::vec_op_e                  op_i,
  input  vec_pkg::elem_t [NrLanes-1:0]      vs1_i,
  input  vec_pkg::elem_t [NrLanes-1:0]      vs2_i,
  input  vec_pkg::elem_t [NrLanes-1:0]      vd_i,
  input  logic           [NrLanes-1:0]      vm_i,
  input  logic                              masked_i,
  // Result valid for one cycle only
  output logic                              out_valid_o,
  output vec_pkg::elem_t [NrLanes-1:0]      res_data_o,
  output logic           [NrLanes-1:0]      res_mask_o,
  output logic           [CntWidth-1:0]     res_count_o
);

  import vec_pkg::*;

  ////////////////////
  // Lanes
  ////////////////////

  // Lane 0's valid stands for all lanes
  logic  [NrLanes-1:0] lane_valid;
  elem_t [NrLanes-1:0] lane_res;

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vec_lane u_lane (
      .clk_i   (clk_i        ),
      .rst_n_i (rst_n_i      ),
      .valid_i (in_valid_i   ),
      .op_i    (op_i         ),
      .vs1_i   (vs1_i[l]     ),
      .vs2_i   (vs2_i[l]     ),
      .valid_o (lane_valid[l]),
      .res_o   (lane_res[l]  )
    );
  end : gen_lanes

  ////////////////////
  // Mask unit
  ////////////////////

  logic  [NrLanes-1:0]  mask_active;
  logic  [NrLanes-1:0]  mask_cmp;
  elem_t [NrLanes-1:0]  mask_vd;
  logic  [CntWidth-1:0] mask_count;

  vec_mask_unit #(
    .NrLanes (NrLanes)
  ) u_mask_unit (
    .clk_i    (clk_i      ),
    .rst_n_i  (rst_n_i    ),
    .valid_i  (in_valid_i ),
    .vs1_i    (vs1_i      ),
    .vs2_i    (vs2_i      ),
    .vd_i     (vd_i       ),
    .vm_i     (vm_i       ),
    .masked_i (masked_i   ),
    .active_o (mask_active),
    .cmp_o    (mask_cmp   ),
    .vd_o     (mask_vd    ),
    .count_o  (mask_count )
  );

  ////////////////////
  // Merge stage
  ////////////////////

  vec_merge #(
    .NrLanes (NrLanes)
  ) u_merge (
    .clk_i       (clk_i        ),
    .rst_n_i     (rst_n_i      ),
    .valid_i     (lane_valid[0]),
    .lane_res_i  (lane_res     ),
    .active_i    (mask_active  ),
    .cmp_i       (mask_cmp     ),
    .vd_i        (mask_vd      ),
    .count_i     (mask_count   ),
    .out_valid_o (out_valid_o  ),
    .res_data_o  (res_data_o   ),
    .res_mask_o  (res_mask_o   ),
    .res_count_o (res_count_o  )
  );

endmodule : vec_top

//--- tb/vec_model.svh
`ifndef VEC_MODEL_SVH
`define VEC_MODEL_SVH

// 32-bit Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  logic fb;
  fb = state[31] ^ state[21] ^ state[1] ^ state[0];
  return {state[30:0], fb};
endfunction

// One element op with a as vs2 and b as vs1
function automatic elem_t elem_op(input logic [2:0] op, input elem_t a, input elem_t b);
  case (op)
    3'd0:    return a + b;
    3'd1:    return a - b;
    3'd2:    return a & b;
    3'd3:    return a | b;
    3'd4:    return a ^ b;
    3'd5:    return (a < b) ? a : b;
    default: return a;
  endcase
endfunction

function automatic vec_t expected_data(input logic [2:0] op, input vec_t vs1, input vec_t vs2,
                                       input vec_t vd, input logic [NrLanes-1:0] active);
  vec_t res;
  for (int l = 0; l < NrLanes; l++) begin
    res[l] = active[l] ? elem_op(op, vs2[l], vs1[l]) : vd[l];
  end
  return res;
endfunction

function automatic logic [NrLanes-1:0] expected_mask(input vec_t vs1, input vec_t vs2,
                                                     input logic [NrLanes-1:0] active);
  logic [NrLanes-1:0] m;
  for (int l = 0; l < NrLanes; l++) begin
    m[l] = active[l] && (vs2[l] < vs1[l]);
  end
  return m;
endfunction

function automatic int count_ones(input logic [NrLanes-1:0] bits);
  int n;
  n = 0;
  for (int l = 0; l < NrLanes; l++) begin
    n += bits[l];
  end
  return n;
endfunction

`endif

//--- tb/tb_vec_top.sv
`timescale 1ns/1ns

module tb_vec_top;

  import vec_pkg::*;

  localparam int unsigned NrLanes     = 4;
  localparam int unsigned CntWidth    = $clog2(NrLanes + 1);
  localparam int unsigned NumInstr    = 300;
  localparam int unsigned DrainCycles = 20;
  localparam logic [31:0] Seed        = 32'h1b4c_beb4;

  typedef elem_t [NrLanes-1:0] vec_t;

  `include "vec_model.svh"

  logic                clk_i;
  logic                rst_n_i;
  logic                in_valid_i;
  vec_op_e             op_i;
  vec_t                vs1_i;
  vec_t                vs2_i;
  vec_t                vd_i;
  logic [NrLanes-1:0]  vm_i;
  logic                masked_i;
  logic                out_valid_o;
  vec_t                res_data_o;
  logic [NrLanes-1:0]  res_mask_o;
  logic [CntWidth-1:0] res_count_o;

  logic [31:0] lfsr_state = Seed;
  int unsigned cyc_cnt = 0;
  int unsigned check_errors = 0;
  int unsigned timeout_errors = 0;

  // Expected results in issue order
  vec_t               exp_data_q[$];
  logic [NrLanes-1:0] exp_mask_q[$];
  int                 exp_count_q[$];
  int unsigned        exp_cyc_q[$];

  vec_top #(
    .NrLanes (NrLanes)
  ) u_dut (
    .clk_i       (clk_i      ),
    .rst_n_i     (rst_n_i    ),
    .in_valid_i  (in_valid_i ),
    .op_i        (op_i       ),
    .vs1_i       (vs1_i      ),
    .vs2_i       (vs2_i      ),
    .vd_i        (vd_i       ),
    .vm_i        (vm_i       ),
    .masked_i    (masked_i   ),
    .out_valid_o (out_valid_o),
    .res_data_o  (res_data_o ),
    .res_mask_o  (res_mask_o ),
    .res_count_o (res_count_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cyc_cnt <= cyc_cnt + 1;
  end

  ////////////////////
  // Stimulus helpers
  ////////////////////

  // Newest LFSR bit goes in at the bottom
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
    return val;
  endfunction

  function automatic vec_t rand_vec();
    vec_t v;
    for (int l = 0; l < NrLanes; l++) begin
      v[l] = elem_t'(rand_bits(ElemWidth));
    end
    return v;
  endfunction

  // Called right after a rising edge
  task automatic send_instr(input logic [2:0] op, input vec_t vs1, input vec_t vs2,
                            input vec_t vd, input logic [NrLanes-1:0] vm, input logic masked);
    logic [NrLanes-1:0] active;
    logic [NrLanes-1:0] exp_mask;
    in_valid_i <= 1'b1;
    op_i       <= vec_op_e'(op);
    vs1_i      <= vs1;
    vs2_i      <= vs2;
    vd_i       <= vd;
    vm_i       <= vm;
    masked_i   <= masked;
    active   = masked ? vm : '1;
    exp_mask = expected_mask(vs1, vs2, active);
    exp_data_q.push_back(expected_data(op, vs1, vs2, vd, active));
    exp_mask_q.push_back(exp_mask);
    exp_count_q.push_back(count_ones(exp_mask));
    // Counter still lags one edge here and lane plus merge registers add two
    exp_cyc_q.push_back(cyc_cnt + 3);
  endtask

  ////////////////////
  // Output checks
  ////////////////////

  task automatic check_output();
    logic               exp_valid;
    vec_t               exp_data;
    logic [NrLanes-1:0] exp_mask;
    int                 exp_count;
    exp_valid = (exp_cyc_q.size() > 0) && (exp_cyc_q[0] == cyc_cnt);
    assert (out_valid_o === exp_valid) else begin
      check_errors++;
      $display("CHECK FAILED at %0t: out_valid_o is %b, expected %b",
               $time, out_valid_o, exp_valid);
    end
    if (exp_valid) begin
      void'(exp_cyc_q.pop_front());
      exp_data  = exp_data_q.pop_front();
      exp_mask  = exp_mask_q.pop_front();
      exp_count = exp_count_q.pop_front();
      if (out_valid_o === 1'b1) begin
        assert (res_data_o === exp_data) else begin
          check_errors++;
          $display("CHECK FAILED at %0t: res_data_o is %h, expected %h",
                   $time, res_data_o, exp_data);
        end
        assert (res_mask_o === exp_mask) else begin
          check_errors++;
          $display("CHECK FAILED at %0t: res_mask_o is %b, expected %b",
                   $time, res_mask_o, exp_mask);
        end
        assert (res_count_o === CntWidth'(exp_count)) else begin
          check_errors++;
          $display("CHECK FAILED at %0t: res_count_o is %0d, expected %0d",
                   $time, res_count_o, exp_count);
        end
      end
    end
  endtask

  // Outputs are settled by the falling edge
  always @(negedge clk_i) begin
    if (rst_n_i === 1'b1) begin
      check_output();
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int unsigned sent;
    rst_n_i    = 1'b0;
    in_valid_i = 1'b0;
    op_i       = VADD;
    vs1_i      = '0;
    vs2_i      = '0;
    vd_i       = '0;
    vm_i       = '0;
    masked_i   = 1'b0;
    sent       = 0;

    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    repeat (3) @(posedge clk_i);

    // No element active so the count is zero
    send_instr(3'd0, rand_vec(), rand_vec(), rand_vec(), '0, 1'b1);
    // Every element active and vs2 < vs1 everywhere
    @(posedge clk_i);
    send_instr(3'd1, {NrLanes{16'hffff}}, '0, rand_vec(), '0, 1'b0);
    @(posedge clk_i);
    send_instr(3'd5, {NrLanes{16'h8000}}, {NrLanes{16'h7fff}}, rand_vec(), '1, 1'b1);
    sent = 3;

    // Random traffic with the strobe high about three cycles of four
    while (sent < NumInstr) begin
      @(posedge clk_i);
      if (rand_bits(2) != 0) begin
        send_instr(3'(rand_bits(3)), rand_vec(), rand_vec(), rand_vec(),
                   NrLanes'(rand_bits(NrLanes)), rand_bits(1) != 0);
        sent++;
      end else begin
        in_valid_i <= 1'b0;
      end
    end
    @(posedge clk_i);
    in_valid_i <= 1'b0;

    for (int i = 0; i < DrainCycles && exp_cyc_q.size() != 0; i++) begin
      @(posedge clk_i);
    end
    if (exp_cyc_q.size() != 0) begin
      timeout_errors++;
      $display("Timeout: %0d results never appeared on the output", exp_cyc_q.size());
    end
    // A few more cycles to catch a stray pulse
    repeat (3) @(posedge clk_i);

    $display("Errors: %0d check, %0d timeout", check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule : tb_vec_top

//--- list.f
+incdir+tb
logic/vec_pkg.sv
logic/vec_lane.sv
logic/vec_mask_unit.sv
logic/vec_merge.sv
logic/vec_top.sv
tb/tb_vec_top.sv
